/* logic/dmaPkg.sv */
package dmaPkg;

	// four channels, as on the 8237
	localparam int numChannels = 4;

	// widths that carry a meaning
	typedef logic [1:0] chanIdxT;
	typedef logic [numChannels-1:0] chanVecT;
	typedef logic [7:0] dataT;
	typedef logic [15:0] addrT;
	typedef logic [15:0] countT;
	typedef logic [3:0] regAddrT;
	typedef logic [1:0] xferT;

	// cpu register map
	// addresses 0..7 are channel registers: bits 2:1 channel, bit 0 address/count
	localparam regAddrT regCommandStatus = 4'd8;
	localparam regAddrT regMode = 4'd11;
	localparam regAddrT regClearFlipFlop = 4'd12;
	localparam regAddrT regMasterClear = 4'd13;

	// command register bits
	localparam int cmdDisableBit = 2;
	localparam int cmdRotateBit = 4;

	// transfer types from mode bits 3:2
	// write moves i/o to memory, read moves memory to i/o
	localparam xferT xferWrite = 2'd1;
	localparam xferT xferRead = 2'd2;

	// transfer states, one-hot
	typedef enum logic [4:0]
	{
		SI = 5'b00001,
		SO = 5'b00010,
		S1 = 5'b00100,
		S2 = 5'b01000,
		S4 = 5'b10000
	} dmaStateT;

	// cpu writes forwarded from the datapath decoder to the control registers
	typedef struct packed
	{
		logic loadCommand;
		logic loadMode;
		logic readStatus;
		logic masterClear;
		dataT data;
	} ctrlWriteT;

	// end-of-transfer report, done is a single cycle pulse in S4
	typedef struct packed
	{
		logic done;
		chanIdxT channel;
		logic terminalCount;
		xferT xferType;
	} serviceT;

endpackage

/* logic/dmaDatapath.sv */
`timescale 1ns/1ps

module dmaDatapath import dmaPkg::*;
(
	input logic busIf,
	input logic rst,
	input logic csN,
	input logic iorN,
	input logic iowN,
	input logic hlda,
	input regAddrT regAddr,
	input dataT dbIn,
	input serviceT service,
	input chanIdxT activeChannel,
	input dataT statusByte,
	output dataT dbOut,
	output ctrlWriteT ctrlWrite,
	output chanVecT armed,
	output addrT currentAddress,
	output logic lastTransfer
);

	logic cpuWrite;
	logic cpuRead;
	logic chanAccess;
	chanIdxT regChan;
	// byte pointer, 0 selects the low byte
	logic bytePtr;
	addrT baseAddr [numChannels];
	addrT curAddr [numChannels];
	countT baseCount [numChannels];
	countT curCount [numChannels];
	addrT addrMerged;
	countT countMerged;
	logic [15:0] readWord;

	// writes only count while the cpu owns the bus
	assign cpuWrite = !csN && !iowN && !hlda;
	assign cpuRead = !csN && !iorN;
	assign chanAccess = !regAddr[3];
	assign regChan = regAddr[2:1];

	// decoded strobes for the command, mode and status registers
	always_comb
	begin
		ctrlWrite.loadCommand = cpuWrite && regAddr == regCommandStatus;
		ctrlWrite.loadMode = cpuWrite && regAddr == regMode;
		ctrlWrite.readStatus = cpuRead && regAddr == regCommandStatus;
		ctrlWrite.masterClear = cpuWrite && regAddr == regMasterClear;
		ctrlWrite.data = dbIn;
	end

	// new byte spliced into the base value of the addressed channel
	always_comb
	begin
		addrMerged = baseAddr[regChan];
		countMerged = baseCount[regChan];
		if (bytePtr)
		begin
			addrMerged[15:8] = dbIn;
			countMerged[15:8] = dbIn;
		end
		else
		begin
			addrMerged[7:0] = dbIn;
			countMerged[7:0] = dbIn;
		end
	end

	always_ff @(posedge busIf)
	begin
		if (rst || ctrlWrite.masterClear)
		begin
			bytePtr <= 1'b0;
			armed <= '0;
		end
		else
		begin
			// every channel access flips the pointer, read or write
			if (chanAccess && (cpuWrite || cpuRead))
				bytePtr <= !bytePtr;
			else if (cpuWrite && regAddr == regClearFlipFlop)
				bytePtr <= 1'b0;
			// a count write arms, the terminal count transfer disarms
			if (chanAccess && cpuWrite && regAddr[0])
				armed[regChan] <= 1'b1;
			else if (service.done && service.terminalCount)
				armed[service.channel] <= 1'b0;
		end
	end

	// address and count storage
	always_ff @(posedge busIf)
	begin
		if (chanAccess && cpuWrite)
		begin
			if (regAddr[0])
			begin
				baseCount[regChan] <= countMerged;
				curCount[regChan] <= countMerged;
			end
			else
			begin
				baseAddr[regChan] <= addrMerged;
				curAddr[regChan] <= addrMerged;
			end
		end
		else if (service.done)
		begin
			curAddr[service.channel] <= curAddr[service.channel] + addrT'(1);
			curCount[service.channel] <= curCount[service.channel] - countT'(1);
		end
	end

	assign currentAddress = curAddr[activeChannel];
	// count of zero means this transfer is the terminal one
	assign lastTransfer = (curCount[activeChannel] == '0);

	// read-back mux, current registers only
	assign readWord = regAddr[0] ? curCount[regChan] : curAddr[regChan];

	always_comb
	begin
		dbOut = '0;
		if (cpuRead)
		begin
			if (chanAccess)
				dbOut = bytePtr ? readWord[15:8] : readWord[7:0];
			else if (regAddr == regCommandStatus)
				dbOut = statusByte;
		end
	end

endmodule

/* logic/controlRegs.sv */
`timescale 1ns/1ps

module controlRegs import dmaPkg::*;
(
	input logic busIf,
	input logic rst,
	input ctrlWriteT ctrlWrite,
	input serviceT service,
	output logic rotatePriority,
	output logic controllerDisable,
	output logic [2*numChannels-1:0] modeTypes,
	output dataT statusByte
);

	dataT commandReg;
	// terminal count flags, one per channel
	chanVecT tcFlags;

	always_ff @(posedge busIf)
	begin
		if (rst || ctrlWrite.masterClear)
		begin
			commandReg <= '0;
			modeTypes <= '0;
			tcFlags <= '0;
		end
		else
		begin
			if (ctrlWrite.loadCommand)
				commandReg <= ctrlWrite.data;
			// mode byte: bits 1:0 pick the channel, bits 3:2 the transfer type
			if (ctrlWrite.loadMode)
				modeTypes[{ctrlWrite.data[1:0], 1'b0} +: 2] <= ctrlWrite.data[3:2];
			// reading status clears the flags
			if (ctrlWrite.readStatus)
				tcFlags <= '0;
			// a new terminal count wins over a clear in the same cycle
			if (service.done && service.terminalCount)
				tcFlags[service.channel] <= 1'b1;
		end
	end

	assign rotatePriority = commandReg[cmdRotateBit];
	assign controllerDisable = commandReg[cmdDisableBit];

	// request bits in the high nibble are not implemented, read as zero
	assign statusByte = {{($bits(dataT) - numChannels){1'b0}}, tcFlags};

endmodule

/* logic/priorityLogic.sv */
`timescale 1ns/1ps

module priorityLogic import dmaPkg::*;
(
	input logic busIf,
	input logic rst,
	input chanVecT dreq,
	input chanVecT armed,
	input logic controllerDisable,
	input logic rotatePriority,
	input serviceT service,
	output chanVecT grant,
	output chanIdxT grantChannel
);

	// slot 0 is highest priority, each slot holds a channel index
	chanIdxT [numChannels-1:0] priorityOrder;
	chanVecT active;
	chanIdxT winner;
	logic found;

	always_comb
	begin
		// only armed channels with a request count, and nothing while disabled
		active = dreq & armed & {numChannels{!controllerDisable}};
		winner = '0;
		found = 1'b0;
		// scan from lowest to highest so the best candidate is written last
		for (int k = numChannels - 1; k >= 0; k--)
		begin
			if (rotatePriority)
			begin
				if (active[priorityOrder[k]])
				begin
					winner = priorityOrder[k];
					found = 1'b1;
				end
			end
			else if (active[k])
			begin
				winner = chanIdxT'(k);
				found = 1'b1;
			end
		end
		grantChannel = winner;
		grant = found ? (chanVecT'(1) << winner) : '0;
	end

	// serviced channel drops to the last slot, the one after it moves to the top
	always_ff @(posedge busIf)
	begin
		if (rst)
		begin
			for (int k = 0; k < numChannels; k++)
				priorityOrder[k] <= chanIdxT'(k);
		end
		else if (service.done && rotatePriority)
		begin
			for (int k = 0; k < numChannels; k++)
				priorityOrder[k] <= service.channel + chanIdxT'(k + 1);
		end
	end

endmodule

/* logic/timingControl.sv */
`timescale 1ns/1ps

module timingControl import dmaPkg::*;
(
	input logic busIf,
	input logic rst,
	input chanVecT grant,
	input chanIdxT grantChannel,
	input logic hlda,
	input logic [2*numChannels-1:0] modeTypes,
	input addrT currentAddress,
	input logic lastTransfer,
	output chanIdxT activeChannel,
	output serviceT service,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output chanVecT dack,
	output addrT address,
	output logic memrN,
	output logic memwN,
	output logic iorOutN,
	output logic iowOutN
);

	dmaStateT state;
	dmaStateT nextState;
	// S1, S2 and S4 own the bus
	logic inCycle;
	logic readPhase;
	logic writePhase;

	always_ff @(posedge busIf)
	begin
		if (rst)
		begin
			state <= SI;
			activeChannel <= '0;
		end
		else
		begin
			state <= nextState;
			// channel is frozen for the whole cycle once we leave idle
			if (state == SI && |grant)
				activeChannel <= grantChannel;
		end
	end

	always_comb
	begin
		nextState = state;
		case (state)
			SI: if (|grant) nextState = SO;
			// hold here until the cpu gives up the bus
			SO: if (hlda) nextState = S1;
			S1: nextState = S2;
			S2: nextState = S4;
			S4: nextState = SI;
			default: nextState = SI;
		endcase
	end

	assign inCycle = (state == S1) || (state == S2) || (state == S4);
	// read strobe spans S2 and S4, write strobe only S4
	assign readPhase = (state == S2) || (state == S4);
	assign writePhase = (state == S4);

	// transfer report, terminal count comes back from the datapath
	always_comb
	begin
		service.done = (state == S4);
		service.channel = activeChannel;
		service.terminalCount = lastTransfer;
		service.xferType = modeTypes[{activeChannel, 1'b0} +: 2];
	end

	assign hrq = (state != SI);
	assign aen = inCycle;
	assign adstb = (state == S1);
	assign dack = inCycle ? (chanVecT'(1) << activeChannel) : '0;
	assign address = inCycle ? currentAddress : '0;

	// read type: memory read then i/o write
	assign memrN = !(readPhase && service.xferType == xferRead);
	assign iowOutN = !(writePhase && service.xferType == xferRead);
	// write type: i/o read then memory write
	assign iorOutN = !(readPhase && service.xferType == xferWrite);
	assign memwN = !(writePhase && service.xferType == xferWrite);

endmodule

/* logic/dmaTop.sv */
`timescale 1ns/1ps

module dmaTop import dmaPkg::*;
(
	input logic busIf,
	input logic rst,
	// cpu programming port
	input logic csN,
	input logic iorN,
	input logic iowN,
	input regAddrT regAddr,
	input dataT dbIn,
	output dataT dbOut,
	// requests and hold handshake
	input chanVecT dreq,
	input logic hlda,
	output logic hrq,
	// transfer bus
	output logic aen,
	output logic adstb,
	output chanVecT dack,
	output addrT address,
	output logic memrN,
	output logic memwN,
	output logic iorOutN,
	output logic iowOutN
);

	// datapath <-> control registers
	ctrlWriteT ctrlWrite;
	dataT statusByte;
	logic rotatePriority;
	logic controllerDisable;
	logic [2*numChannels-1:0] modeTypes;

	// arbitration
	chanVecT armed;
	chanVecT grant;
	chanIdxT grantChannel;

	// transfer engine
	chanIdxT activeChannel;
	serviceT service;
	addrT currentAddress;
	logic lastTransfer;

	dmaDatapath d
	(
		.busIf(busIf), .rst(rst), .csN(csN), .iorN(iorN), .iowN(iowN), .hlda(hlda),
		.regAddr(regAddr), .dbIn(dbIn), .service(service), .activeChannel(activeChannel),
		.statusByte(statusByte), .dbOut(dbOut), .ctrlWrite(ctrlWrite), .armed(armed),
		.currentAddress(currentAddress), .lastTransfer(lastTransfer)
	);

	controlRegs cR
	(
		.busIf(busIf), .rst(rst), .ctrlWrite(ctrlWrite), .service(service),
		.rotatePriority(rotatePriority), .controllerDisable(controllerDisable),
		.modeTypes(modeTypes), .statusByte(statusByte)
	);

	priorityLogic pL
	(
		.busIf(busIf), .rst(rst), .dreq(dreq), .armed(armed),
		.controllerDisable(controllerDisable), .rotatePriority(rotatePriority),
		.service(service), .grant(grant), .grantChannel(grantChannel)
	);

	timingControl tC
	(
		.busIf(busIf), .rst(rst), .grant(grant), .grantChannel(grantChannel), .hlda(hlda),
		.modeTypes(modeTypes), .currentAddress(currentAddress), .lastTransfer(lastTransfer),
		.activeChannel(activeChannel), .service(service), .hrq(hrq), .aen(aen),
		.adstb(adstb), .dack(dack), .address(address), .memrN(memrN), .memwN(memwN),
		.iorOutN(iorOutN), .iowOutN(iowOutN)
	);

endmodule

/* verification/clockGen.sv */
`timescale 1ns/1ps

module clockGen
(
	output logic busIf,
	output logic rst
);

	// 4 ns period
	initial
	begin
		busIf = 1'b0;
		forever #2 busIf = !busIf;
	end

	// reset held for 16 rising edges, released just after the edge
	initial
	begin
		rst = 1'b1;
		repeat (16) @(posedge busIf);
		#1 rst = 1'b0;
	end

endmodule

/* verification/dmaTb.sv */
`timescale 1ns/1ps

module dmaTb import dmaPkg::*; ();

	logic busIf;
	logic rst;
	logic csN;
	logic iorN;
	logic iowN;
	regAddrT regAddr;
	dataT dbIn;
	dataT dbOut;
	chanVecT dreq;
	logic hlda;
	logic hrq;
	logic aen;
	logic adstb;
	chanVecT dack;
	addrT address;
	logic memrN;
	logic memwN;
	logic iorOutN;
	logic iowOutN;

	// model of what the cpu programmed and what transfers have done
	addrT modelAddr [numChannels];
	addrT modelBaseAddr [numChannels];
	countT modelBaseCount [numChannels];
	countT modelCount [numChannels];
	xferT modelMode [numChannels];
	chanVecT modelArmed;
	chanVecT modelTc;
	logic modelPtr;
	logic rotateOn;
	// last channel served in rotating mode
	// starting from 3 puts channel 0 on top
	chanIdxT lastServiced;
	int servedQ [$];
	int transfersSeen;
	int errCount;
	int failCount;
	string testName;
	logic [31:0] lcgState;

	clockGen clk (.busIf(busIf), .rst(rst));

	dmaTop uut (.*);

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// returns the channel that should win or -1 when no armed channel requests
	function automatic int expectedChannel(chanVecT req, chanVecT armedBits, logic rotate,
		chanIdxT last);
		chanVecT live;
		chanIdxT idx;
		int result;
		live = req & armedBits;
		result = -1;
		// walk from highest priority down and keep the first hit
		for (int k = 0; k < numChannels; k++)
		begin
			idx = rotate ? chanIdxT'(int'(last) + 1 + k) : chanIdxT'(k);
			if (result < 0 && live[idx])
				result = int'(idx);
		end
		return result;
	endfunction

	// {memrN, memwN, iorOutN, iowOutN} for a transfer type and phase
	function automatic logic [3:0] expectedStrobes(xferT kind, logic readOn, logic writeOn);
		logic [3:0] s;
		s = 4'b1111;
		if (kind == xferRead)
		begin
			s[3] = !readOn;
			s[0] = !writeOn;
		end
		else if (kind == xferWrite)
		begin
			s[1] = !readOn;
			s[2] = !writeOn;
		end
		return s;
	endfunction

	task automatic compareValue(string what, logic [15:0] expected, logic [15:0] actual);
		assert (actual === expected)
		else
		begin
			errCount++;
			$display("ERR %s %s expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic stepCycle();
		@(posedge busIf);
		#1;
	endtask

	task automatic writeReg(regAddrT ra, dataT value);
		chanIdxT chan;
		chan = ra[2:1];
		stepCycle();
		csN = 1'b0;
		iowN = 1'b0;
		regAddr = ra;
		dbIn = value;
		stepCycle();
		csN = 1'b1;
		iowN = 1'b1;
		// a channel byte goes into base and current alike
		if (ra < regCommandStatus)
		begin
			if (ra[0])
			begin
				modelBaseCount[chan][{modelPtr, 3'b000} +: 8] = value;
				modelCount[chan] = modelBaseCount[chan];
				modelArmed[chan] = 1'b1;
			end
			else
			begin
				modelBaseAddr[chan][{modelPtr, 3'b000} +: 8] = value;
				modelAddr[chan] = modelBaseAddr[chan];
			end
			modelPtr = !modelPtr;
		end
		else if (ra == regClearFlipFlop)
			modelPtr = 1'b0;
		else if (ra == regMode)
			modelMode[value[1:0]] = value[3:2];
		else if (ra == regCommandStatus)
			rotateOn = value[cmdRotateBit];
	endtask

	// dbOut is sampled mid cycle, side effects land on the closing edge
	task automatic readExpect(regAddrT ra, dataT expected, string what);
		dataT value;
		stepCycle();
		csN = 1'b0;
		iorN = 1'b0;
		regAddr = ra;
		#2;
		value = dbOut;
		stepCycle();
		csN = 1'b1;
		iorN = 1'b1;
		compareValue(what, 16'(expected), 16'(value));
		if (ra < regCommandStatus)
			modelPtr = !modelPtr;
		else if (ra == regCommandStatus)
			modelTc = '0;
	endtask

	// raise requests, grant the bus after a random delay, drop both when the cycle ends
	task automatic serveRequest(chanVecT pattern);
		int n;
		int delay;
		stepCycle();
		dreq = pattern;
		n = 0;
		while (!hrq && n < 20)
		begin
			stepCycle();
			n++;
		end
		assert (hrq)
		else
		begin
			failCount++;
			$display("%s timeout, hold request never rose for dreq %b", testName, pattern);
		end
		if (hrq)
		begin
			delay = int'(nextRandom() >> 30);
			repeat (delay) stepCycle();
			hlda = 1'b1;
			n = 0;
			while (!aen && n < 20)
			begin
				stepCycle();
				n++;
			end
			assert (aen)
			else
			begin
				failCount++;
				$display("%s timeout, transfer never started after hold acknowledge", testName);
			end
			n = 0;
			while (aen && n < 20)
			begin
				stepCycle();
				n++;
			end
			assert (!aen)
			else
			begin
				failCount++;
				$display("%s timeout, transfer never released the bus", testName);
			end
		end
		dreq = '0;
		hlda = 1'b0;
		// the checker closes its SI check and the model one step later
		stepCycle();
	endtask

	task automatic checkPhase(string phase, chanIdxT ch, logic strobe, logic readOn,
		logic writeOn);
		compareValue({phase, " aen"}, 16'd1, 16'(aen));
		compareValue({phase, " adstb"}, 16'(strobe), 16'(adstb));
		compareValue({phase, " dack"}, 16'(chanVecT'(1) << ch), 16'(dack));
		compareValue({phase, " address"}, modelAddr[ch], address);
		compareValue({phase, " strobes"}, 16'(expectedStrobes(modelMode[ch], readOn, writeOn)),
			16'({memrN, memwN, iorOutN, iowOutN}));
	endtask

	// follows one transfer from S1 back to SI, then advances the model
	task automatic checkTransfer();
		int expCh;
		chanIdxT ch;
		expCh = expectedChannel(dreq, modelArmed, rotateOn, lastServiced);
		assert (expCh >= 0)
		else
		begin
			failCount++;
			$display("%s transfer started with no eligible request, dreq %b", testName, dreq);
		end
		ch = chanIdxT'(expCh);
		checkPhase("S1", ch, 1'b1, 1'b0, 1'b0);
		@(posedge busIf);
		#2;
		checkPhase("S2", ch, 1'b0, 1'b1, 1'b0);
		@(posedge busIf);
		#2;
		checkPhase("S4", ch, 1'b0, 1'b1, 1'b1);
		@(posedge busIf);
		#2;
		compareValue("SI hrq aen dack", 16'd0, 16'({hrq, aen, dack}));
		// the transfer that starts from a zero count is the terminal one
		if (modelCount[ch] == '0)
		begin
			modelTc[ch] = 1'b1;
			modelArmed[ch] = 1'b0;
		end
		modelAddr[ch] = modelAddr[ch] + addrT'(1);
		modelCount[ch] = modelCount[ch] - countT'(1);
		if (rotateOn)
			lastServiced = ch;
		servedQ.push_back(int'(ch));
		transfersSeen++;
	endtask

	// the first cycle with aen or adstb high is S1
	// sampled between the drive point and the next edge
	always @(posedge busIf)
	begin
		#2;
		if (!rst && (aen || adstb))
			checkTransfer();
	end

	initial
	begin
		int n;
		int start;
		chanIdxT c;
		countT tcCount;
		chanVecT pattern;
		csN = 1'b1;
		iorN = 1'b1;
		iowN = 1'b1;
		regAddr = '0;
		dbIn = '0;
		dreq = '0;
		hlda = 1'b0;
		lcgState = 32'hcabe_7d74;
		errCount = 0;
		failCount = 0;
		transfersSeen = 0;
		modelMode = '{default: '0};
		modelArmed = '0;
		modelTc = '0;
		modelPtr = 1'b0;
		rotateOn = 1'b0;
		lastServiced = 2'd3;

		testName = "reset";
		// reset is only looked at once the clock runs
		stepCycle();
		n = 0;
		while (rst && n < 100)
		begin
			stepCycle();
			n++;
		end
		assert (!rst)
		else
		begin
			failCount++;
			$display("reset never released");
		end
		compareValue("idle outputs", 16'd0, 16'({hrq, aen, adstb, dack}));
		compareValue("idle strobes", 16'hf, 16'({memrN, memwN, iorOutN, iowOutN}));
		readExpect(regCommandStatus, 8'h00, "status");

		testName = "readback";
		writeReg(regClearFlipFlop, 8'h00);
		for (int ch = 0; ch < numChannels; ch++)
		begin
			// address low, high, then count low, high
			for (int b = 0; b < 4; b++)
				writeReg(regAddrT'(2 * ch + b / 2), dataT'(nextRandom() >> 24));
		end
		writeReg(regClearFlipFlop, 8'h00);
		for (int ch = 0; ch < numChannels; ch++)
		begin
			c = chanIdxT'(ch);
			readExpect(regAddrT'(2 * ch), modelAddr[c][7:0], "address low");
			readExpect(regAddrT'(2 * ch), modelAddr[c][15:8], "address high");
			readExpect(regAddrT'(2 * ch + 1), modelCount[c][7:0], "count low");
			readExpect(regAddrT'(2 * ch + 1), modelCount[c][15:8], "count high");
		end

		testName = "single";
		// even channels read memory, odd channels write it
		for (int ch = 0; ch < numChannels; ch++)
			writeReg(regMode, dataT'({(ch[0] ? xferWrite : xferRead), 2'(ch)}));
		for (int ch = 0; ch < numChannels; ch++)
			serveRequest(chanVecT'(1) << ch);

		testName = "terminal";
		c = chanIdxT'(nextRandom() >> 30);
		tcCount = countT'(nextRandom() >> 30) + countT'(1);
		writeReg(regClearFlipFlop, 8'h00);
		writeReg(regAddrT'({c, 1'b0}), dataT'(nextRandom() >> 24));
		writeReg(regAddrT'({c, 1'b0}), dataT'(nextRandom() >> 24));
		writeReg(regAddrT'({c, 1'b1}), tcCount[7:0]);
		writeReg(regAddrT'({c, 1'b1}), tcCount[15:8]);
		start = transfersSeen;
		for (int k = 0; k <= int'(tcCount); k++)
			serveRequest(chanVecT'(1) << c);
		compareValue("transfer count", 16'(int'(tcCount) + 1), 16'(transfersSeen - start));
		// request held on a disarmed channel must not reach hrq
		stepCycle();
		dreq = chanVecT'(1) << c;
		for (int k = 0; k < 8; k++)
		begin
			stepCycle();
			compareValue("hrq after terminal count", 16'd0, 16'(hrq));
		end
		dreq = '0;
		readExpect(regCommandStatus, dataT'(modelTc | (chanVecT'(1) << c)), "status");
		readExpect(regCommandStatus, 8'h00, "status second read");

		testName = "fixed priority";
		writeReg(regClearFlipFlop, 8'h00);
		for (int ch = 0; ch < numChannels; ch++)
		begin
			writeReg(regAddrT'(2 * ch), dataT'(nextRandom() >> 24));
			writeReg(regAddrT'(2 * ch), dataT'(nextRandom() >> 24));
			// a count of 256 gives 257 transfers and this test uses far fewer
			writeReg(regAddrT'(2 * ch + 1), 8'h00);
			writeReg(regAddrT'(2 * ch + 1), 8'h01);
		end
		for (int k = 0; k < 10; k++)
		begin
			pattern = chanVecT'(nextRandom() >> 28);
			serveRequest(pattern == '0 ? 4'b1000 : pattern);
		end

		testName = "rotating priority";
		writeReg(regCommandStatus, dataT'(1 << cmdRotateBit));
		servedQ.delete();
		for (int k = 0; k < numChannels; k++)
			serveRequest(4'b1111);
		compareValue("rotation length", 16'(numChannels), 16'(servedQ.size()));
		for (int k = 0; k < servedQ.size(); k++)
			compareValue("rotation order", 16'(k), 16'(servedQ[k]));
		for (int k = 0; k < 10; k++)
		begin
			pattern = chanVecT'(nextRandom() >> 28);
			serveRequest(pattern == '0 ? 4'b0100 : pattern);
		end

		stepCycle();
		$display("errors %0d value mismatches, %0d other failures", errCount, failCount);
		if (errCount == 0 && failCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* sources.f */
logic/dmaPkg.sv
logic/dmaDatapath.sv
logic/controlRegs.sv
logic/priorityLogic.sv
logic/timingControl.sv
logic/dmaTop.sv
verification/clockGen.sv
verification/dmaTb.sv

/* Makefile */
# simulator, top module and build location can be overridden on the command line
VERILATOR ?= verilator
TOP ?= dmaTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing

# every source named in the file list, so a change triggers a rebuild
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# fails unless the simulation prints the pass line
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(BUILD_DIR)
